// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mbox_ctrl_tb -f tb.f -o mbox_ctrl_sim

# the simulator's own status is not trusted, the log decides
./obj_dir/mbox_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb.f
verilog/mbox_pkg.sv
verilog/ss_frame_collector.sv
verilog/req_arbiter.sv
verilog/mbox_regfile.sv
verilog/mbox_ctrl_top.sv
test/tb_clock_gen.sv
test/mbox_ctrl_properties.sv
test/mbox_ctrl_tb.sv

// File: test/mbox_ctrl_properties.sv
// concurrent checks on the LS handshake, the access pulse and the interrupt; bound into the top level
`timescale 1ns/1ps
module mbox_ctrl_properties (
    input logic axi_aclk,
    input logic axi_aresetn,
    input logic bk_ls_valid,
    input logic bk_ls_ready,
    input logic acc_valid,
    input logic axi_interrupt
);

    // ready only answers a pending request
    ls_ready_needs_valid: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        $rose(bk_ls_ready) |-> bk_ls_valid
    ) else $error("bk_ls_ready rose while bk_ls_valid was low");

    // enable and status only move on the edge of a register file access
    irq_follows_access: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        $changed(axi_interrupt) |-> $past(acc_valid)
    ) else $error("axi_interrupt changed without a register file access");

    // one register file access per grant
    acc_valid_single_cycle: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        acc_valid |=> !acc_valid
    ) else $error("acc_valid stayed high for two cycles");

endmodule

bind mbox_ctrl_top mbox_ctrl_properties u_props (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .bk_ls_valid   (bk_ls_valid),
    .bk_ls_ready   (bk_ls_ready),
    .acc_valid     (acc_valid),
    .axi_interrupt (axi_interrupt)
);

// File: test/mbox_ctrl_tb.sv
// table-driven testbench for the mailbox register block; run through tb.f as top module mbox_ctrl_tb
`timescale 1ns/1ps
module mbox_ctrl_tb;
    import mbox_pkg::*;

    localparam int clk_period = 40;

    typedef enum {k_ls_wr, k_ls_rd, k_ss, k_both} step_kind_e;

    typedef struct {
        string                name;
        step_kind_e           kind;
        logic [ls_addr_w-1:0] addr;
        logic [data_w-1:0]    data;
        logic [strb_w-1:0]    strb;
        logic [1:0]           user;
        logic [data_w-1:0]    exp_rdata;
        logic                 exp_irq;
    } step_t;

    logic                 axi_aclk;
    logic                 axi_aresetn;
    logic                 bk_ls_valid = 1'b0;
    ls_req_t              bk_ls_req   = '0;
    logic                 bk_ls_ready;
    logic [data_w-1:0]    bk_ls_rdata;
    logic                 bk_ss_valid = 1'b0;
    logic [data_w-1:0]    bk_ss_data  = '0;
    logic [1:0]           bk_ss_user  = 2'b00;
    logic                 bk_ss_ready;
    logic                 axi_interrupt;

    step_t                steps[$];
    logic                 table_built = 1'b0;
    logic [31:0]          lcg_state   = 32'hece828ec;
    // register model
    logic [data_w-1:0]    mb_m[mb_count];
    logic                 m_en = 1'b0;
    logic                 m_st = 1'b0;

    tb_clock_gen u_clk (.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn));

    mbox_ctrl_top uut (.*);

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_mailbox(input logic [ls_addr_w-1:0] addr);
        return (addr >= mb_low) && (addr <= mb_high);
    endfunction

    task automatic store_bytes(input logic [ls_addr_w-1:0] addr, input logic [data_w-1:0] data,
                               input logic [strb_w-1:0] strb);
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                mb_m[addr[4:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic ls_write_effect(input logic [ls_addr_w-1:0] addr,
                                   input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
        if (is_mailbox(addr)) begin
            store_bytes(addr, data, strb);
        end else if (addr == aa_enable_addr && strb[0]) begin
            m_en = data[0];
        end else if (addr == aa_status_addr && strb[0] && data[0]) begin
            m_st = 1'b0;
        end
    endtask

    // remote writes land only in the mailbox
    task automatic ss_write_effect(input logic [ls_addr_w-1:0] addr,
                                   input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
        if (is_mailbox(addr)) begin
            store_bytes(addr, data, strb);
            m_st = 1'b1;
        end
    endtask

    function automatic logic [data_w-1:0] read_value(input logic [ls_addr_w-1:0] addr);
        if (is_mailbox(addr)) begin
            return mb_m[addr[4:2]];
        end else if (addr == aa_enable_addr) begin
            return {31'd0, m_en};
        end else if (addr == aa_status_addr) begin
            return {31'd0, m_st};
        end
        return 32'hFFFF_FFFF;
    endfunction

    // the SS half of a joint step writes the next word with inverted data
    task automatic add_step(input string name, input step_kind_e kind,
                            input logic [ls_addr_w-1:0] addr, input logic [data_w-1:0] data,
                            input logic [strb_w-1:0] strb, input logic [1:0] user);
        step_t s;
        s.name = name;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        s.strb = strb;
        s.user = user;
        if (kind == k_ls_wr || kind == k_both) begin
            ls_write_effect(addr, data, strb);
        end
        if ((kind == k_ss && user == 2'b01) || kind == k_both) begin
            ss_write_effect((kind == k_both) ? addr + 15'd4 : addr,
                            (kind == k_both) ? ~data : data, strb);
        end
        s.exp_rdata = read_value(addr);
        s.exp_irq   = m_en && m_st;
        steps.push_back(s);
    endtask

    // ------------------------------------------------------------------------
    // bus drivers enter and leave 2 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic ls_access(input logic rd, input logic [ls_addr_w-1:0] addr,
                             input logic [data_w-1:0] data, input logic [strb_w-1:0] strb,
                             output logic [data_w-1:0] rdata);
        bk_ls_req.rd_wr = rd;
        bk_ls_req.addr  = addr;
        bk_ls_req.wdata = data;
        bk_ls_req.wstrb = strb;
        bk_ls_valid     = 1'b1;
        do @(negedge axi_aclk); while (!bk_ls_ready);
        rdata = bk_ls_rdata;
        @(posedge axi_aclk);
        #2 bk_ls_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [data_w-1:0] word, input logic [1:0] user);
        bk_ss_valid = 1'b1;
        bk_ss_data  = word;
        bk_ss_user  = user;
        do @(negedge axi_aclk); while (!bk_ss_ready);
        @(posedge axi_aclk);
        #2 bk_ss_valid = 1'b0;
    endtask

    task automatic send_frame(input logic [ls_addr_w-1:0] addr, input logic [data_w-1:0] data,
                              input logic [strb_w-1:0] strb, input logic [1:0] user);
        send_beat({strb, 13'd0, addr}, user);
        send_beat(data, user);
        // ready returns once the held frame has been written
        do @(negedge axi_aclk); while (!bk_ss_ready);
        @(posedge axi_aclk);
        #2;
    endtask

    initial begin
        logic [31:0]       rnd;
        logic [data_w-1:0] rdata;
        logic              ok;
        int                n_pass;
        int                n_fail;
        n_pass = 0;
        n_fail = 0;
        for (int i = 0; i < mb_count; i++) begin
            mb_m[i] = '0;
        end
        rnd = lcg_next();
        add_step("mb1_full_wr", k_ls_wr, 15'h2004, lcg_next(), 4'hF, 2'b00);
        add_step("mb1_part_wr", k_ls_wr, 15'h2004, lcg_next(), rnd[3:0], 2'b00);
        add_step("mb1_rd", k_ls_rd, 15'h2004, '0, 4'h0, 2'b00);
        add_step("hole_rd_2020", k_ls_rd, 15'h2020, '0, 4'h0, 2'b00);
        add_step("hole_rd_2108", k_ls_rd, 15'h2108, '0, 4'h0, 2'b00);
        add_step("outside_rd_4000", k_ls_rd, 15'h4000, '0, 4'h0, 2'b00);
        add_step("hole_wr_2108", k_ls_wr, 15'h2108, 32'hFFFF_FFFF, 4'hF, 2'b00);
        add_step("mb1_rd_after_hole", k_ls_rd, 15'h2004, '0, 4'h0, 2'b00);
        // word index bits of 0x2108 point at mailbox word 2
        add_step("mb2_rd_after_hole", k_ls_rd, 15'h2008, '0, 4'h0, 2'b00);
        add_step("enable_rd_after_hole", k_ls_rd, 15'h2100, '0, 4'h0, 2'b00);
        add_step("enable_wr", k_ls_wr, 15'h2100, 32'hFFFF_FFFF, 4'hF, 2'b00);
        add_step("enable_rd", k_ls_rd, 15'h2100, '0, 4'h0, 2'b00);
        add_step("ss_mb2_wr", k_ss, 15'h2008, lcg_next(), 4'hF, 2'b01);
        add_step("mb2_rd", k_ls_rd, 15'h2008, '0, 4'h0, 2'b00);
        add_step("status_wr0", k_ls_wr, 15'h2104, 32'h0, 4'hF, 2'b00);
        add_step("status_rd_set", k_ls_rd, 15'h2104, '0, 4'h0, 2'b00);
        // status is set here, so a hole write that reached it would clear it
        add_step("hole_wr_2108_set", k_ls_wr, 15'h2108, 32'hFFFF_FFFF, 4'hF, 2'b00);
        add_step("status_rd_after_hole", k_ls_rd, 15'h2104, '0, 4'h0, 2'b00);
        add_step("status_wr1", k_ls_wr, 15'h2104, 32'h1, 4'hF, 2'b00);
        add_step("status_rd_clr", k_ls_rd, 15'h2104, '0, 4'h0, 2'b00);
        add_step("ss_enable_drop", k_ss, 15'h2100, 32'h0, 4'hF, 2'b01);
        add_step("enable_rd_kept", k_ls_rd, 15'h2100, '0, 4'h0, 2'b00);
        add_step("ss_user10_drop", k_ss, 15'h200C, lcg_next(), 4'hF, 2'b10);
        add_step("mb3_rd_untouched", k_ls_rd, 15'h200C, '0, 4'h0, 2'b00);
        add_step("ls_ss_together", k_both, 15'h2010, lcg_next(), 4'hF, 2'b01);
        add_step("mb4_rd", k_ls_rd, 15'h2010, '0, 4'h0, 2'b00);
        add_step("mb5_rd", k_ls_rd, 15'h2014, '0, 4'h0, 2'b00);
        table_built = 1'b1;

        @(posedge axi_aresetn);
        @(posedge axi_aclk);
        #2;
        foreach (steps[i]) begin
            ok    = 1'b1;
            rdata = '0;
            case (steps[i].kind)
                k_ls_wr: ls_access(1'b0, steps[i].addr, steps[i].data, steps[i].strb, rdata);
                k_ls_rd: ls_access(1'b1, steps[i].addr, '0, 4'h0, rdata);
                k_ss:    send_frame(steps[i].addr, steps[i].data, steps[i].strb, steps[i].user);
                default: begin
                    fork
                        send_frame(steps[i].addr + 15'd4, ~steps[i].data, steps[i].strb,
                                   steps[i].user);
                        begin
                            // LS reaches the arbiter in the cycle the frame request appears
                            repeat (3) @(posedge axi_aclk);
                            #2;
                            ls_access(1'b0, steps[i].addr, steps[i].data, steps[i].strb,
                                      rdata);
                        end
                    join
                end
            endcase
            if (steps[i].kind == k_ls_rd && rdata !== steps[i].exp_rdata) begin
                $display("[ERROR] %s: expected %h, actual %h", steps[i].name,
                         steps[i].exp_rdata, rdata);
                ok = 1'b0;
            end
            if (axi_interrupt !== steps[i].exp_irq) begin
                $display("[ERROR] %s axi_interrupt: expected %b, actual %b", steps[i].name,
                         steps[i].exp_irq, axi_interrupt);
                ok = 1'b0;
            end
            if (ok) begin
                n_pass++;
                $display("[PASS] %s", steps[i].name);
            end else begin
                n_fail++;
                $display("[FAIL] %s", steps[i].name);
            end
        end
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // about 20 cycles per step
    initial begin
        wait (table_built);
        #(steps.size() * 20 * clk_period);
        $display("timeout: the steps did not finish within %0d cycles", steps.size() * 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
// clock and reset source for the mailbox testbench; reset is held low for the first few clock edges
`timescale 1ns/1ps
module tb_clock_gen (
    output logic axi_aclk,
    output logic axi_aresetn
);
    localparam int half_period_ns = 20;
    localparam int reset_cycles   = 4;

    initial begin
        axi_aclk = 1'b0;
        forever #(half_period_ns) axi_aclk = ~axi_aclk;
    end

    // released just after the last reset edge
    initial begin
        axi_aresetn = 1'b0;
        repeat (reset_cycles) @(posedge axi_aclk);
        #2 axi_aresetn = 1'b1;
    end

endmodule

// File: verilog/mbox_ctrl_top.sv
`timescale 1ns/1ps
// top of the mailbox register block; connects the stream collector, arbiter and register file
module mbox_ctrl_top (
    input  logic                        axi_aclk,
    input  logic                        axi_aresetn,

    // AXI-Lite slave side backend (LS)
    input  logic                        bk_ls_valid,
    input  mbox_pkg::ls_req_t           bk_ls_req,
    output logic                        bk_ls_ready,
    output logic [mbox_pkg::data_w-1:0] bk_ls_rdata,

    // AXI-Stream slave side backend (SS)
    input  logic                        bk_ss_valid,
    input  logic [mbox_pkg::data_w-1:0] bk_ss_data,
    input  logic [1:0]                  bk_ss_user,
    output logic                        bk_ss_ready,

    output logic                        axi_interrupt
);
    import mbox_pkg::*;

    // collector to arbiter
    logic     ss_req_valid;
    acc_req_t ss_req;
    logic     ss_req_take;

    // arbiter to register file
    logic     acc_valid;
    acc_req_t acc_req;

    ss_frame_collector u_collector (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .bk_ss_valid  (bk_ss_valid),
        .bk_ss_data   (bk_ss_data),
        .bk_ss_user   (bk_ss_user),
        .bk_ss_ready  (bk_ss_ready),
        .ss_req_valid (ss_req_valid),
        .ss_req       (ss_req),
        .ss_req_take  (ss_req_take)
    );

    req_arbiter u_arbiter (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .bk_ls_valid  (bk_ls_valid),
        .bk_ls_req    (bk_ls_req),
        .bk_ls_ready  (bk_ls_ready),
        .ss_req_valid (ss_req_valid),
        .ss_req       (ss_req),
        .ss_req_take  (ss_req_take),
        .acc_valid    (acc_valid),
        .acc_req      (acc_req)
    );

    // read data goes straight back to LS, valid while bk_ls_ready is high
    mbox_regfile u_regfile (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .acc_valid     (acc_valid),
        .acc_req       (acc_req),
        .acc_rdata     (bk_ls_rdata),
        .axi_interrupt (axi_interrupt)
    );

endmodule

// File: verilog/mbox_pkg.sv
// address map, widths and request types shared by every module of the mailbox register block
package mbox_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------
    localparam int data_w    = 32;
    localparam int ls_addr_w = 15;
    localparam int strb_w    = 4;
    localparam int mb_count  = 8;

    // -------------------------------------------------------------------------
    // local address map, LS byte addresses
    // -------------------------------------------------------------------------
    localparam logic [ls_addr_w-1:0] mb_low         = 15'h2000;
    localparam logic [ls_addr_w-1:0] mb_high        = 15'h201F;
    localparam logic [ls_addr_w-1:0] aa_enable_addr = 15'h2100;
    localparam logic [ls_addr_w-1:0] aa_status_addr = 15'h2104;
    localparam logic [ls_addr_w-1:0] local_high     = 15'h2FFF;

    // returned for any read that hits no register
    localparam logic [data_w-1:0] unsupp_rdata = 32'hFFFF_FFFF;

    // -------------------------------------------------------------------------
    // request types
    // -------------------------------------------------------------------------

    // one LS access as presented on the request/ready port
    typedef struct packed {
        logic                 rd_wr;   // set for a read
        logic [ls_addr_w-1:0] addr;
        logic [data_w-1:0]    wdata;
        logic [strb_w-1:0]    wstrb;
    } ls_req_t;

    // stream user codes, only 01 is served here
    typedef enum logic [1:0] {
        ss_user_wr      = 2'b01,
        ss_user_rd_req  = 2'b10,
        ss_user_rd_data = 2'b11
    } ss_user_e;

    typedef enum logic {
        src_ls = 1'b0,
        src_ss = 1'b1
    } req_src_e;

    // one access to the register file, from either side
    typedef struct packed {
        req_src_e             src;
        logic                 rd_wr;   // set for a read
        logic [ls_addr_w-1:0] addr;
        logic [data_w-1:0]    data;
        logic [strb_w-1:0]    strb;
    } acc_req_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_fetch,
        arb_exec,
        arb_reply
    } arb_state_e;

    // address class inside the register file
    typedef enum logic [1:0] {
        acc_mb,
        acc_enable,
        acc_status,
        acc_unsupp
    } acc_kind_e;

endpackage

// File: verilog/mbox_regfile.sv
`timescale 1ns/1ps
// mailbox and interrupt control registers; decodes each access, returns read data, drives the interrupt
module mbox_regfile (
    input  logic                        axi_aclk,
    input  logic                        axi_aresetn,
    input  logic                        acc_valid,
    input  mbox_pkg::acc_req_t          acc_req,
    output logic [mbox_pkg::data_w-1:0] acc_rdata,
    output logic                        axi_interrupt
);
    import mbox_pkg::*;

    acc_kind_e                       acc_kind;
    logic                            in_local;
    logic [$clog2(mb_count)-1:0]     mb_idx;
    logic                            is_wr;
    logic                            ls_wr;
    logic                            ss_mb_wr;
    logic [mb_count-1:0][data_w-1:0] mb_regs;
    logic                            int_enable;
    logic                            int_status;

    // -------------------------------------------------------------------------
    // address decode
    // -------------------------------------------------------------------------
    assign in_local = (acc_req.addr >= mb_low) && (acc_req.addr <= local_high);

    // word index inside the mailbox
    assign mb_idx = acc_req.addr[$clog2(mb_count)+1:2];

    always_comb begin
        if (!in_local) begin
            acc_kind = acc_unsupp;
        end else if (acc_req.addr <= mb_high) begin
            acc_kind = acc_mb;
        end else if (acc_req.addr[ls_addr_w-1:2] == aa_enable_addr[ls_addr_w-1:2]) begin
            acc_kind = acc_enable;
        end else if (acc_req.addr[ls_addr_w-1:2] == aa_status_addr[ls_addr_w-1:2]) begin
            acc_kind = acc_status;
        end else begin
            // holes in the local window read all ones
            acc_kind = acc_unsupp;
        end
    end

    assign is_wr    = acc_valid && !acc_req.rd_wr;
    assign ls_wr    = is_wr && (acc_req.src == src_ls);
    assign ss_mb_wr = is_wr && (acc_req.src == src_ss) && (acc_kind == acc_mb);

    // -------------------------------------------------------------------------
    // mailbox, byte-strobed writes from either side
    // -------------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            mb_regs <= '0;
        end else if (is_wr && acc_kind == acc_mb) begin
            for (int b = 0; b < strb_w; b++) begin
                if (acc_req.strb[b]) begin
                    mb_regs[mb_idx][b*8 +: 8] <= acc_req.data[b*8 +: 8];
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // interrupt enable and status
    // -------------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            int_enable <= 1'b0;
            int_status <= 1'b0;
        end else begin
            // enable bit 0 is read-write from LS
            if (ls_wr && acc_kind == acc_enable && acc_req.strb[0]) begin
                int_enable <= acc_req.data[0];
            end
            // remote mailbox write raises status, LS clears it by writing one
            if (ss_mb_wr) begin
                int_status <= 1'b1;
            end else if (ls_wr && acc_kind == acc_status && acc_req.strb[0]
                         && acc_req.data[0]) begin
                int_status <= 1'b0;
            end
        end
    end

    // -------------------------------------------------------------------------
    // read data, registered on the access edge
    // -------------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            acc_rdata <= '0;
        end else if (acc_valid) begin
            case (acc_kind)
                acc_mb:     acc_rdata <= mb_regs[mb_idx];
                acc_enable: acc_rdata <= {{(data_w-1){1'b0}}, int_enable};
                acc_status: acc_rdata <= {{(data_w-1){1'b0}}, int_status};
                default:    acc_rdata <= unsupp_rdata;
            endcase
        end
    end

    assign axi_interrupt = int_enable && int_status;

endmodule

// File: verilog/req_arbiter.sv
`timescale 1ns/1ps
// round-robin arbiter between LS and SS requests; sequences one register file access at a time
module req_arbiter (
    input  logic               axi_aclk,
    input  logic               axi_aresetn,

    // LS request/ready
    input  logic               bk_ls_valid,
    input  mbox_pkg::ls_req_t  bk_ls_req,
    output logic               bk_ls_ready,

    // SS request from the frame collector
    input  logic               ss_req_valid,
    input  mbox_pkg::acc_req_t ss_req,
    output logic               ss_req_take,

    // register file access
    output logic               acc_valid,
    output mbox_pkg::acc_req_t acc_req
);
    import mbox_pkg::*;

    arb_state_e state;
    arb_state_e state_nxt;
    req_src_e   last_src;
    logic       any_req;
    logic       ls_wins;
    acc_req_t   ls_acc;

    assign any_req = bk_ls_valid || ss_req_valid;

    // on a tie the source not served last goes first
    assign ls_wins = bk_ls_valid && (!ss_req_valid || last_src == src_ss);

    // LS request in register file form
    always_comb begin
        ls_acc.src   = src_ls;
        ls_acc.rd_wr = bk_ls_req.rd_wr;
        ls_acc.addr  = bk_ls_req.addr;
        ls_acc.data  = bk_ls_req.wdata;
        ls_acc.strb  = bk_ls_req.wstrb;
    end

    // -------------------------------------------------------------------------
    // access sequencing FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            arb_idle: begin
                if (any_req) begin
                    state_nxt = arb_fetch;
                end
            end
            arb_fetch: begin
                // request withdrawn in the meantime
                state_nxt = any_req ? arb_exec : arb_idle;
            end
            arb_exec: begin
                state_nxt = arb_reply;
            end
            arb_reply: begin
                state_nxt = arb_idle;
            end
            default: state_nxt = arb_idle;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state    <= arb_idle;
            // so that LS takes the first tie
            last_src <= src_ss;
        end else begin
            state <= state_nxt;
            if (state == arb_fetch && any_req) begin
                last_src <= ls_wins ? src_ls : src_ss;
            end
        end
    end

    // winner captured in fetch, held through execute and reply
    always_ff @(posedge axi_aclk) begin
        if (state == arb_fetch) begin
            acc_req <= ls_wins ? ls_acc : ss_req;
        end
    end

    assign acc_valid = (state == arb_exec);

    // one-cycle acknowledge to whichever side was served
    assign bk_ls_ready = (state == arb_reply) && (acc_req.src == src_ls);
    assign ss_req_take = (state == arb_reply) && (acc_req.src == src_ss);

endmodule

// File: verilog/ss_frame_collector.sv
`timescale 1ns/1ps
// turns two-beat AXI-Stream write frames (user 01) into register write requests, drops the rest
module ss_frame_collector (
    input  logic                        axi_aclk,
    input  logic                        axi_aresetn,
    input  logic                        bk_ss_valid,
    input  logic [mbox_pkg::data_w-1:0] bk_ss_data,
    input  logic [1:0]                  bk_ss_user,
    output logic                        bk_ss_ready,
    output logic                        ss_req_valid,
    output mbox_pkg::acc_req_t          ss_req,
    input  logic                        ss_req_take
);
    import mbox_pkg::*;

    typedef enum logic [1:0] {
        beat_hdr,
        beat_data,
        beat_held
    } beat_state_e;

    beat_state_e          state;
    beat_state_e          state_nxt;
    logic                 beat_xfer;
    logic                 user_wr;
    logic                 hdr_wide;
    logic [strb_w-1:0]    hdr_strb;
    logic [ls_addr_w-1:0] hdr_addr;
    logic [data_w-1:0]    frame_data;

    assign beat_xfer = bk_ss_valid && bk_ss_ready;

    always_comb begin
        case (ss_user_e'(bk_ss_user))
            ss_user_wr:                      user_wr = 1'b1;
            // read request and read return belong to the forwarding path
            ss_user_rd_req, ss_user_rd_data: user_wr = 1'b0;
            default:                         user_wr = 1'b0;
        endcase
    end

    // -------------------------------------------------------------------------
    // beat FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            beat_hdr: begin
                if (beat_xfer && user_wr) begin
                    state_nxt = beat_data;
                end
            end
            beat_data: begin
                // wide header or odd user code on the data beat drops the frame
                if (beat_xfer) begin
                    state_nxt = (user_wr && !hdr_wide) ? beat_held : beat_hdr;
                end
            end
            beat_held: begin
                if (ss_req_take) begin
                    state_nxt = beat_hdr;
                end
            end
            default: state_nxt = beat_hdr;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state        <= beat_hdr;
            bk_ss_ready  <= 1'b0;
            ss_req_valid <= 1'b0;
            hdr_wide     <= 1'b0;
        end else begin
            state        <= state_nxt;
            bk_ss_ready  <= (state_nxt != beat_held);
            // one cycle after the frame completes
            ss_req_valid <= (state == beat_held) && !ss_req_take;
            if (state == beat_hdr && beat_xfer && user_wr) begin
                hdr_wide <= |bk_ss_data[data_w-strb_w-1:ls_addr_w];
            end
        end
    end

    // header is strobe over address, data beat follows
    always_ff @(posedge axi_aclk) begin
        if (state == beat_hdr && beat_xfer) begin
            hdr_strb <= bk_ss_data[data_w-1 -: strb_w];
            hdr_addr <= bk_ss_data[ls_addr_w-1:0];
        end
        if (state == beat_data && beat_xfer) begin
            frame_data <= bk_ss_data;
        end
    end

    always_comb begin
        ss_req.src   = src_ss;
        ss_req.rd_wr = 1'b0;
        ss_req.addr  = hdr_addr;
        ss_req.data  = frame_data;
        ss_req.strb  = hdr_strb;
    end

endmodule
